//--- src/lsu_pkg.sv
/*
 * lsu package
 * Shared widths, memory latency and operation encodings for the
 * memory-access stage. The store width codes reuse the encodings
 * of the matching signed loads.
 */
package lsu_pkg;

    // data path and field widths
    localparam int XLEN        = 64;
    localparam int ADDR_W      = 64;
    localparam int REG_ADDR_W  = 5;
    localparam int INST_W      = 32;

    // 256 doublewords of data memory
    localparam int RAM_DEPTH_W = 8;

    // cycles a request stays active, finish cycle included
    localparam int MEM_LATENCY = 2;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10,
        MEM_FENCE = 2'b11
    } mem_op_e;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } ls_sel_e;

    // store widths share the signed load codes
    localparam ls_sel_e SB = LB;
    localparam ls_sel_e SH = LH;
    localparam ls_sel_e SW = LW;
    localparam ls_sel_e SD = LD;

endpackage

//--- src/ex_mem_reg.sv
/*
 * ex_mem_reg
 * Pipeline register between execute and memory. Captures the
 * execute-side fields on every edge without a stall and holds
 * them while the memory stage is busy.
 */
`timescale 1ns/10ps

module ex_mem_reg
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,

    input  logic                  valid_i,
    input  mem_op_e               mem_op_i,
    input  ls_sel_e               ls_sel_i,
    input  logic                  rd_ena_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  word_t                 rd_data_i,
    input  logic [ADDR_W-1:0]     ls_addr_i,
    input  logic [ADDR_W-1:0]     pc_i,
    input  logic [INST_W-1:0]     inst_i,

    output logic                  valid_o,
    output mem_op_e               mem_op_o,
    output ls_sel_e               ls_sel_o,
    output logic                  rd_ena_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output word_t                 rd_data_o,
    output logic [ADDR_W-1:0]     ls_addr_o,
    output logic [ADDR_W-1:0]     pc_o,
    output logic [INST_W-1:0]     inst_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            mem_op_o  <= MEM_NONE;
            ls_sel_o  <= LB;
            rd_ena_o  <= 1'b0;
            rd_addr_o <= '0;
            rd_data_o <= '0;
            ls_addr_o <= '0;
            pc_o      <= '0;
            inst_o    <= '0;
        end else if (!stall_i) begin
            valid_o   <= valid_i;
            mem_op_o  <= mem_op_i;
            ls_sel_o  <= ls_sel_i;
            rd_ena_o  <= rd_ena_i;
            rd_addr_o <= rd_addr_i;
            rd_data_o <= rd_data_i;
            ls_addr_o <= ls_addr_i;
            pc_o      <= pc_i;
            inst_o    <= inst_i;
        end
    end

endmodule

//--- src/load_store.sv
/*
 * load_store
 * Memory-stage datapath. Decodes the access width, places store
 * data in its byte lanes with a matching write mask, extracts and
 * extends load data, and holds the pipeline until the data memory
 * reports that the access has finished.
 */
`timescale 1ns/10ps

module load_store
    import lsu_pkg::*;
(
    input  logic                  valid_i,
    input  mem_op_e               mem_op_i,
    input  ls_sel_e               ls_sel_i,
    input  logic                  rd_ena_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  word_t                 rd_data_i,
    input  logic [ADDR_W-1:0]     ls_addr_i,
    input  logic [ADDR_W-1:0]     pc_i,
    input  logic [INST_W-1:0]     inst_i,
    input  word_t                 mem_rdata_i,
    input  logic                  mem_finish_i,

    output logic [ADDR_W-1:0]     mem_addr_o,
    output word_t                 mem_wdata_o,
    output logic [7:0]            mem_wmask_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic                  mem_fence_o,
    output logic                  stall_o,
    output logic                  valid_o,
    output logic                  rd_ena_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output word_t                 rd_data_o,
    output logic [ADDR_W-1:0]     pc_o,
    output logic [INST_W-1:0]     inst_o
);

    logic       mem_active;
    logic       is_load;
    logic       is_store;
    logic [5:0] byte_shift;
    logic [5:0] half_shift;
    logic [5:0] word_shift;
    word_t      rd_byte_w;
    word_t      rd_half_w;
    word_t      rd_word_w;
    word_t      load_data;
    word_t      store_data;
    logic [7:0] store_mask;

    assign mem_active = valid_i && (mem_op_i != MEM_NONE);
    assign is_load    = valid_i && (mem_op_i == MEM_LOAD);
    assign is_store   = valid_i && (mem_op_i == MEM_STORE);

    // bit offsets of the naturally aligned lane for each width
    assign byte_shift = {ls_addr_i[2:0], 3'b000};
    assign half_shift = {ls_addr_i[2:1], 4'b0000};
    assign word_shift = {ls_addr_i[2], 5'b00000};

    // store lane placement and byte mask
    always_comb begin
        case (ls_sel_i)
            SB: begin
                store_data = {{(XLEN-8){1'b0}}, rd_data_i[7:0]} << byte_shift;
                store_mask = 8'b0000_0001 << ls_addr_i[2:0];
            end
            SH: begin
                store_data = {{(XLEN-16){1'b0}}, rd_data_i[15:0]} << half_shift;
                store_mask = 8'b0000_0011 << {ls_addr_i[2:1], 1'b0};
            end
            SW: begin
                store_data = {{(XLEN-32){1'b0}}, rd_data_i[31:0]} << word_shift;
                store_mask = 8'b0000_1111 << {ls_addr_i[2], 2'b00};
            end
            SD: begin
                store_data = rd_data_i;
                store_mask = 8'b1111_1111;
            end
            default: begin
                store_data = '0;
                store_mask = 8'b0000_0000;
            end
        endcase
    end

    // move the addressed lane down to bit 0
    assign rd_byte_w = mem_rdata_i >> byte_shift;
    assign rd_half_w = mem_rdata_i >> half_shift;
    assign rd_word_w = mem_rdata_i >> word_shift;

    always_comb begin
        case (ls_sel_i)
            LB:      load_data = {{(XLEN-8){rd_byte_w[7]}}, rd_byte_w[7:0]};
            LH:      load_data = {{(XLEN-16){rd_half_w[15]}}, rd_half_w[15:0]};
            LW:      load_data = {{(XLEN-32){rd_word_w[31]}}, rd_word_w[31:0]};
            LD:      load_data = mem_rdata_i;
            LBU:     load_data = {{(XLEN-8){1'b0}}, rd_byte_w[7:0]};
            LHU:     load_data = {{(XLEN-16){1'b0}}, rd_half_w[15:0]};
            LWU:     load_data = {{(XLEN-32){1'b0}}, rd_word_w[31:0]};
            default: load_data = '0;
        endcase
    end

    // request stays up as a level until the finish pulse
    assign mem_req_o   = mem_active;
    assign mem_we_o    = is_store;
    assign mem_fence_o = mem_active && (mem_op_i == MEM_FENCE);
    assign mem_addr_o  = ls_addr_i;
    assign mem_wdata_o = is_store ? store_data : '0;
    assign mem_wmask_o = is_store ? store_mask : 8'b0000_0000;
    assign stall_o     = mem_active && !mem_finish_i;

    // results toward writeback
    assign valid_o   = valid_i;
    assign rd_ena_o  = rd_ena_i;
    assign rd_addr_o = rd_addr_i;
    assign rd_data_o = is_load ? load_data : rd_data_i;
    assign pc_o      = pc_i;
    assign inst_o    = inst_i;

endmodule

//--- src/data_ram.sv
/*
 * data_ram
 * Byte-masked doubleword data memory with a fixed access latency.
 * A request is a level; finish_o pulses in its last cycle, when
 * read data is valid and the masked store is committed.
 */
`timescale 1ns/10ps

module data_ram
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic              fence_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  word_t             wdata_i,
    input  logic [7:0]        wmask_i,
    output word_t             rdata_o,
    output logic              finish_o
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    word_t                  ram_q [0:(1 << RAM_DEPTH_W)-1];
    logic [RAM_DEPTH_W-1:0] word_idx;
    logic [CNT_W-1:0]       lat_cnt_q;
    logic                   wr_en;

    // doubleword index wraps at the memory depth
    assign word_idx = addr_i[RAM_DEPTH_W+2:3];

    assign finish_o = req_i && (lat_cnt_q == CNT_W'(MEM_LATENCY - 1));

    // a fence only waits out the latency
    assign wr_en = finish_o && we_i && !fence_i;

    assign rdata_o = ram_q[word_idx];

    // counter restarts after every finish so back-to-back
    // requests each take the full latency
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lat_cnt_q <= '0;
        end else if (!req_i || finish_o) begin
            lat_cnt_q <= '0;
        end else begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < XLEN / 8; b++) begin
            if (wr_en && wmask_i[b]) begin
                ram_q[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

//--- src/mem_wb_reg.sv
/*
 * mem_wb_reg
 * Register between memory and writeback. Inserts a bubble while
 * the memory stage stalls so each instruction is seen only once.
 */
`timescale 1ns/10ps

module mem_wb_reg
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,

    input  logic                  valid_i,
    input  logic                  rd_ena_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  word_t                 rd_data_i,
    input  logic [ADDR_W-1:0]     pc_i,
    input  logic [INST_W-1:0]     inst_i,

    output logic                  valid_o,
    output logic                  rd_ena_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output word_t                 rd_data_o,
    output logic [ADDR_W-1:0]     pc_o,
    output logic [INST_W-1:0]     inst_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            rd_ena_o  <= 1'b0;
            rd_addr_o <= '0;
            rd_data_o <= '0;
            pc_o      <= '0;
            inst_o    <= '0;
        end else begin
            // bubble while the access is still in progress
            valid_o   <= valid_i && !stall_i;
            rd_ena_o  <= rd_ena_i && valid_i && !stall_i;
            rd_addr_o <= rd_addr_i;
            rd_data_o <= rd_data_i;
            pc_o      <= pc_i;
            inst_o    <= inst_i;
        end
    end

endmodule

//--- src/mem_subsys_top.sv
/*
 * mem_subsys_top
 * Memory-access stage: execute/memory register, load/store unit,
 * data memory and memory/writeback register chained together.
 */
`timescale 1ns/10ps

module mem_subsys_top
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  mem_op_e               mem_op_i,
    input  ls_sel_e               ls_sel_i,
    input  logic                  rd_ena_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  word_t                 rd_data_i,
    input  logic [ADDR_W-1:0]     ls_addr_i,
    input  logic [ADDR_W-1:0]     pc_i,
    input  logic [INST_W-1:0]     inst_i,
    output logic                  stall_o,
    output logic                  wb_valid_o,
    output logic                  wb_rd_ena_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output word_t                 wb_rd_data_o,
    output logic [ADDR_W-1:0]     wb_pc_o,
    output logic [INST_W-1:0]     wb_inst_o
);

    // execute/memory register outputs
    logic                  em_valid;
    mem_op_e               em_mem_op;
    ls_sel_e               em_ls_sel;
    logic                  em_rd_ena;
    logic [REG_ADDR_W-1:0] em_rd_addr;
    word_t                 em_rd_data;
    logic [ADDR_W-1:0]     em_ls_addr;
    logic [ADDR_W-1:0]     em_pc;
    logic [INST_W-1:0]     em_inst;

    // memory interface
    logic [ADDR_W-1:0]     mem_addr;
    word_t                 mem_wdata;
    logic [7:0]            mem_wmask;
    logic                  mem_req;
    logic                  mem_we;
    logic                  mem_fence;
    word_t                 mem_rdata;
    logic                  mem_finish;
    logic                  mem_stall;

    // load/store results toward writeback
    logic                  ls_valid;
    logic                  ls_rd_ena;
    logic [REG_ADDR_W-1:0] ls_rd_addr;
    word_t                 ls_rd_data;
    logic [ADDR_W-1:0]     ls_pc;
    logic [INST_W-1:0]     ls_inst;

    assign stall_o = mem_stall;

    ex_mem_reg ex_mem_reg_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (mem_stall),
        .valid_i   (valid_i),
        .mem_op_i  (mem_op_i),
        .ls_sel_i  (ls_sel_i),
        .rd_ena_i  (rd_ena_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_i (rd_data_i),
        .ls_addr_i (ls_addr_i),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .valid_o   (em_valid),
        .mem_op_o  (em_mem_op),
        .ls_sel_o  (em_ls_sel),
        .rd_ena_o  (em_rd_ena),
        .rd_addr_o (em_rd_addr),
        .rd_data_o (em_rd_data),
        .ls_addr_o (em_ls_addr),
        .pc_o      (em_pc),
        .inst_o    (em_inst)
    );

    load_store load_store_i (
        .valid_i      (em_valid),
        .mem_op_i     (em_mem_op),
        .ls_sel_i     (em_ls_sel),
        .rd_ena_i     (em_rd_ena),
        .rd_addr_i    (em_rd_addr),
        .rd_data_i    (em_rd_data),
        .ls_addr_i    (em_ls_addr),
        .pc_i         (em_pc),
        .inst_i       (em_inst),
        .mem_rdata_i  (mem_rdata),
        .mem_finish_i (mem_finish),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_wmask_o  (mem_wmask),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_fence_o  (mem_fence),
        .stall_o      (mem_stall),
        .valid_o      (ls_valid),
        .rd_ena_o     (ls_rd_ena),
        .rd_addr_o    (ls_rd_addr),
        .rd_data_o    (ls_rd_data),
        .pc_o         (ls_pc),
        .inst_o       (ls_inst)
    );

    data_ram data_ram_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (mem_req),
        .we_i     (mem_we),
        .fence_i  (mem_fence),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .wmask_i  (mem_wmask),
        .rdata_o  (mem_rdata),
        .finish_o (mem_finish)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (mem_stall),
        .valid_i   (ls_valid),
        .rd_ena_i  (ls_rd_ena),
        .rd_addr_i (ls_rd_addr),
        .rd_data_i (ls_rd_data),
        .pc_i      (ls_pc),
        .inst_i    (ls_inst),
        .valid_o   (wb_valid_o),
        .rd_ena_o  (wb_rd_ena_o),
        .rd_addr_o (wb_rd_addr_o),
        .rd_data_o (wb_rd_data_o),
        .pc_o      (wb_pc_o),
        .inst_o    (wb_inst_o)
    );

endmodule

//--- verification/tb_mem_subsys.sv
/*
 * tb_mem_subsys
 * Table-driven testbench for the memory-access stage. Each entry is
 * applied one at a time; a byte-level memory model gives the expected
 * writeback data, and every entry is checked for latency and bubbles.
 */
`timescale 1ns/10ps

module tb_mem_subsys
    import lsu_pkg::*;
;

    localparam int          WAIT_LIMIT = 32;
    localparam logic [31:0] SEED       = 32'h3b17_88f5;

    typedef struct packed {
        mem_op_e               op;
        ls_sel_e               sel;
        logic [ADDR_W-1:0]     addr;
        word_t                 data;
        logic                  rd_ena;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [ADDR_W-1:0]     pc;
        logic [INST_W-1:0]     inst;
        word_t                 exp_data;
    } entry_t;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  valid_i;
    mem_op_e               mem_op_i;
    ls_sel_e               ls_sel_i;
    logic                  rd_ena_i;
    logic [REG_ADDR_W-1:0] rd_addr_i;
    word_t                 rd_data_i;
    logic [ADDR_W-1:0]     ls_addr_i;
    logic [ADDR_W-1:0]     pc_i;
    logic [INST_W-1:0]     inst_i;
    logic                  stall_o;
    logic                  wb_valid_o;
    logic                  wb_rd_ena_o;
    logic [REG_ADDR_W-1:0] wb_rd_addr_o;
    word_t                 wb_rd_data_o;
    logic [ADDR_W-1:0]     wb_pc_o;
    logic [INST_W-1:0]     wb_inst_o;

    entry_t     table_q [$];
    // reference memory, one byte per address
    logic [7:0] model_mem [bit [ADDR_W-1:0]];

    mem_subsys_top dut_i (.*);

    always #2 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [REG_ADDR_W-1:0] exp,
                                  input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic word_t rand_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic int access_bytes(input ls_sel_e sel);
        case (sel)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // gather bytes little-endian, then extend from the top loaded bit
    function automatic word_t load_value(input ls_sel_e sel, input logic [ADDR_W-1:0] addr);
        word_t v;
        int    n;
        v = '0;
        n = access_bytes(sel);
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model_mem[addr + ADDR_W'(i)];
        end
        if ((sel == LB || sel == LH || sel == LW) && v[8*n-1]) begin
            for (int i = 8 * n; i < XLEN; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic push_entry(input mem_op_e op, input ls_sel_e sel,
                              input logic [ADDR_W-1:0] addr, input word_t data,
                              input logic rd_ena, input word_t exp_data);
        entry_t e;
        e.op       = op;
        e.sel      = sel;
        e.addr     = addr;
        e.data     = data;
        e.rd_ena   = rd_ena;
        e.rd_addr  = REG_ADDR_W'(table_q.size() + 1);
        e.pc       = 64'h0000_0000_8000_0000 + ADDR_W'(4 * table_q.size());
        e.inst     = 32'h0000_0003 | INST_W'(table_q.size() << 7);
        e.exp_data = exp_data;
        table_q.push_back(e);
    endtask

    task automatic add_store(input ls_sel_e sel, input logic [ADDR_W-1:0] addr,
                             input word_t data);
        for (int i = 0; i < access_bytes(sel); i++) begin
            model_mem[addr + ADDR_W'(i)] = data[8*i +: 8];
        end
        push_entry(MEM_STORE, sel, addr, data, 1'b0, data);
    endtask

    task automatic add_load(input ls_sel_e sel, input logic [ADDR_W-1:0] addr);
        push_entry(MEM_LOAD, sel, addr, 64'hdead_beef_dead_beef, 1'b1, load_value(sel, addr));
    endtask

    task automatic build_table();
        word_t             pattern;
        word_t             w;
        logic [ADDR_W-1:0] base;
        // doubleword round trip
        add_store(SD, 64'h100, rand_word());
        add_load(LD, 64'h100);
        // narrow stores into a filled doubleword
        add_store(SD, 64'h200, rand_word());
        for (int b = 0; b < 8; b++) begin
            add_store(SB, 64'h200 + ADDR_W'(b), rand_word());
            add_load(LD, 64'h200);
        end
        for (int h = 0; h < 4; h++) begin
            add_store(SH, 64'h200 + ADDR_W'(2 * h), rand_word());
            add_load(LD, 64'h200);
        end
        add_store(SW, 64'h204, rand_word());
        add_load(LD, 64'h200);
        // second doubleword inverts every sign bit of the first
        pattern = 64'h7f80_12f3_8a01_6c9e;
        add_store(SD, 64'h300, pattern);
        add_store(SD, 64'h308, ~pattern);
        for (int d = 0; d < 2; d++) begin
            base = 64'h300 + ADDR_W'(8 * d);
            for (int b = 0; b < 8; b++) begin
                add_load(LB, base + ADDR_W'(b));
                add_load(LBU, base + ADDR_W'(b));
            end
            for (int h = 0; h < 4; h++) begin
                add_load(LH, base + ADDR_W'(2 * h));
                add_load(LHU, base + ADDR_W'(2 * h));
            end
            for (int q = 0; q < 2; q++) begin
                add_load(LW, base + ADDR_W'(4 * q));
                add_load(LWU, base + ADDR_W'(4 * q));
            end
        end
        // plain pass-through
        for (int k = 0; k < 4; k++) begin
            w = rand_word();
            push_entry(MEM_NONE, LB, 64'h0, w, k[0], w);
        end
        // fence must leave the doubleword untouched
        add_store(SD, 64'h400, rand_word());
        w = rand_word();
        push_entry(MEM_FENCE, LD, 64'h400, w, 1'b1, w);
        add_load(LD, 64'h400);
    endtask

    task automatic run_entry(input entry_t e);
        int waited;
        int edges;
        int stall_cycles;
        int exp_edges;
        exp_edges = (e.op == MEM_NONE) ? 1 : MEM_LATENCY;
        @(posedge clk);
        #1;
        valid_i   = 1'b1;
        mem_op_i  = e.op;
        ls_sel_i  = e.sel;
        rd_ena_i  = e.rd_ena;
        rd_addr_i = e.rd_addr;
        rd_data_i = e.data;
        ls_addr_i = e.addr;
        pc_i      = e.pc;
        inst_i    = e.inst;
        // hold the inputs until the stage is free
        waited = 0;
        @(negedge clk);
        while (stall_o) begin
            check_bit("wb_valid_o", 1'b0, wb_valid_o);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("entry was never accepted");
            end
            @(negedge clk);
        end
        check_bit("wb_valid_o", 1'b0, wb_valid_o);
        @(posedge clk);
        #1;
        // bubble keeps the operation code so only valid_i marks it empty
        valid_i = 1'b0;
        // count edges from acceptance up to the writeback
        edges        = 0;
        stall_cycles = 0;
        @(negedge clk);
        while (!wb_valid_o) begin
            if (stall_o) begin
                stall_cycles++;
            end
            @(posedge clk);
            edges++;
            if (edges > WAIT_LIMIT) begin
                report_timeout("no writeback for the accepted entry");
            end
            @(negedge clk);
        end
        check_word("wb_rd_data_o", e.exp_data, wb_rd_data_o);
        check_reg_addr("wb_rd_addr_o", e.rd_addr, wb_rd_addr_o);
        check_bit("wb_rd_ena_o", e.rd_ena, wb_rd_ena_o);
        check_word("wb_pc_o", e.pc, wb_pc_o);
        check_word("wb_inst_o", XLEN'(e.inst), XLEN'(wb_inst_o));
        check_word("writeback edges", XLEN'(exp_edges), XLEN'(edges));
        check_word("stall cycles", XLEN'(exp_edges - 1), XLEN'(stall_cycles));
        check_bit("stall_o", 1'b0, stall_o);
    endtask

    initial begin
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        mem_op_i  = MEM_NONE;
        ls_sel_i  = LB;
        rd_ena_i  = 1'b0;
        rd_addr_i = '0;
        rd_data_i = '0;
        ls_addr_i = '0;
        pc_i      = '0;
        inst_i    = '0;
        void'($urandom(SEED));
        build_table();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_bit("stall_o", 1'b0, stall_o);
            check_bit("wb_valid_o", 1'b0, wb_valid_o);
        end
        @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_bit("stall_o", 1'b0, stall_o);
        check_bit("wb_valid_o", 1'b0, wb_valid_o);
        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sim.f
src/lsu_pkg.sv
src/ex_mem_reg.sv
src/load_store.sv
src/data_ram.sv
src/mem_wb_reg.sv
src/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run for the memory-access stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run passed, see $(LOG)"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
